// ==== project.f ====
cl_tick_pkg.sv
ocl_reg_slice.sv
ocl_reg_file.sv
tick_counter.sv
cl_tick_counter_top.sv
cl_tick_counter_properties.sv
tb_cl_tick_counter_top.sv

// ==== Makefile ====
TOP := tb_cl_tick_counter_top

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -o vsim
	./obj_dir/vsim | tee sim.log
	grep -q "^STATUS: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_cl_tick_counter_top.sv ====
`timescale 1ns/1ps

module tb_cl_tick_counter_top import cl_tick_pkg::*;
();

  localparam logic [data_w-1:0] id0_val     = 32'hF000_1D0F;
  localparam logic [data_w-1:0] id1_val     = 32'h1D51_FEDC;
  localparam logic [data_w-1:0] version_val = 32'hEEEE_EE00;
  localparam int max_cycles = 20000;  // tests take about 5000 cycles

  typedef logic [data_w-1:0] shadow_t [0:15];  // one word per register slot, offset / 4

  logic              clk_main_a0 = 1'b0;
  logic              rst_main_n, awvalid, wvalid, arvalid;
  logic              awready, wready, bvalid, arready, rvalid;
  logic              bready = 1'b0;  // owned by the ready driver
  logic              rready = 1'b0;
  logic [addr_w-1:0] awaddr, araddr;
  logic [data_w-1:0] wdata, rdata;
  logic [strb_w-1:0] wstrb;
  logic [1:0]        bresp, rresp;

  shadow_t           shadow;
  logic [1:0]        exp_b_q [$];                // expected bresp, in issue order
  logic [33:0]       exp_r_q [$];                // expected {rresp, rdata}
  logic [off_w-1:0]  exp_off_q [$];              // offset of each read, for messages
  logic [1:0]        exp_b;
  logic [33:0]       exp_r;
  logic [off_w-1:0]  exp_off;
  int                wr_req, rd_req, b_cnt, r_cnt, val_err, proto_err, cycles;
  integer            seed = 32'h4b10_5374;
  integer            rdy_seed = 32'h4b10_5374;  // separate stream for bready/rready
  integer            rnd, rdy_rnd;
  logic [data_w-1:0] d0, d1;
  logic              heavy_stall = 1'b0;

  cl_tick_counter_top #(
    .cl_id0     (id0_val),
    .cl_id1     (id1_val),
    .cl_version (version_val)
  ) u_dut (.*);

  bind ocl_reg_file cl_tick_counter_properties u_props (.*);

  always #5 clk_main_a0 = ~clk_main_a0;  // 10 ns period

  // ------------------------------------------------------------
  // reference model
  // ------------------------------------------------------------
  function automatic logic [data_w-1:0] merge_bytes(input logic [data_w-1:0] old_v,
                                                    input logic [data_w-1:0] new_v,
                                                    input logic [strb_w-1:0] strb);
    logic [data_w-1:0] m;
    for (int i = 0; i < strb_w; i++)
      m[8*i +: 8] = strb[i] ? new_v[8*i +: 8] : old_v[8*i +: 8];
    return m;
  endfunction

  // expected {resp, data} of a read at off
  function automatic logic [33:0] ref_read(input logic [off_w-1:0] off, input shadow_t sh);
    logic [data_w-1:0] d;
    logic [1:0]        resp;
    d    = '0;
    resp = resp_okay;
    case (off)
      reg_id0:        d = id0_val;
      reg_id1:        d = id1_val;
      reg_status:     d = status_word;
      reg_version:    d = version_val;
      reg_ctrl:       d = sh[4] & 32'h3;            // pulse bits never read back
      reg_tick_value: d = sh[5] & 32'hFF;
      reg_load_value: d = sh[6] & 32'hFFFF;
      reg_watermark:  d = sh[7] & 32'hFFFF;
      reg_count:      d = sh[8] & 32'hFFFF;
      reg_tick_count: d = sh[9] & 32'hFF;
      reg_flags:
      begin
        d[0] = (sh[8][15:0] >= sh[7][15:0]);     // count vs watermark
        d[1] = (sh[9][7:0] >= sh[5][7:0]);       // prescaler at terminal
      end
      default:        resp = resp_slverr;
    endcase
    return {resp, d};
  endfunction

  // apply a write to the shadow, return the expected bresp
  function automatic logic [1:0] shadow_write(input logic [off_w-1:0] off,
                                              input logic [data_w-1:0] data,
                                              input logic [strb_w-1:0] strb);
    logic [1:0] resp;
    resp = resp_okay;
    case (off)
      reg_ctrl:
      begin
        if (strb[0])
        begin
          shadow[4] = data & 32'h3;
          if (data[3])
          begin
            shadow[8] = '0;                        // clear beats load
            shadow[9] = '0;
          end
          else if (data[2])
            shadow[8] = shadow[6] & 32'hFFFF;
        end
      end
      reg_tick_value: shadow[5] = merge_bytes(shadow[5], data, strb) & 32'hFF;
      reg_load_value: shadow[6] = merge_bytes(shadow[6], data, strb) & 32'hFFFF;
      reg_watermark:  shadow[7] = merge_bytes(shadow[7], data, strb) & 32'hFFFF;
      default:        resp = resp_slverr;         // ro or hole, nothing changes
    endcase
    return resp;
  endfunction

  // ------------------------------------------------------------
  // bus tasks, entered and left 1 ns after a rising edge
  // ------------------------------------------------------------
  task automatic axi_write(input logic [off_w-1:0] off, input logic [data_w-1:0] data,
                           input logic [strb_w-1:0] strb, input bit wait_resp);
    logic aw_hs, w_hs;
    exp_b_q.push_back(shadow_write(off, data, strb));
    wr_req++;
    awaddr  = {24'h0, off};
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    while (awvalid || wvalid)
    begin
      @(negedge clk_main_a0);
      aw_hs = awvalid & awready;                   // transfer at the coming edge
      w_hs  = wvalid & wready;
      @(posedge clk_main_a0);
      #1;
      if (aw_hs)
        awvalid = 1'b0;
      if (w_hs)
        wvalid = 1'b0;
    end
    if (wait_resp)
    begin
      wait (b_cnt == wr_req);
      @(posedge clk_main_a0);
      #1;
    end
  endtask

  task automatic axi_read(input logic [off_w-1:0] off, input bit wait_resp);
    logic ar_hs;
    exp_r_q.push_back(ref_read(off, shadow));
    exp_off_q.push_back(off);
    rd_req++;
    araddr  = {24'h0, off};
    arvalid = 1'b1;
    while (arvalid)
    begin
      @(negedge clk_main_a0);
      ar_hs = arvalid & arready;
      @(posedge clk_main_a0);
      #1;
      if (ar_hs)
        arvalid = 1'b0;
    end
    if (wait_resp)
    begin
      wait (r_cnt == rd_req);
      @(posedge clk_main_a0);
      #1;
    end
  endtask

  // random back-pressure on b and r
  always @(posedge clk_main_a0)
  begin
    #1;
    rdy_rnd = $random(rdy_seed);
    bready  = heavy_stall ? (rdy_rnd[1:0] == 2'b00) : rdy_rnd[0];
    rready  = heavy_stall ? (rdy_rnd[3:2] == 2'b00) : rdy_rnd[1];
  end

  // ------------------------------------------------------------
  // compare, sampled mid cycle where the bus is stable
  // ------------------------------------------------------------
  always @(negedge clk_main_a0)
  begin
    if (rst_main_n && bvalid && bready)
    begin
      b_cnt++;
      assert (exp_b_q.size() > 0)
      else
      begin
        $display("write response arrived with no write outstanding");
        proto_err++;
      end
      if (exp_b_q.size() > 0)
      begin
        exp_b = exp_b_q.pop_front();
        assert (bresp == exp_b)
        else
        begin
          $display("ERROR: bresp got 0x%h expected 0x%h", bresp, exp_b);
          val_err++;
        end
      end
    end
    if (rst_main_n && rvalid && rready)
    begin
      r_cnt++;
      assert (exp_r_q.size() > 0)
      else
      begin
        $display("read response arrived with no read outstanding");
        proto_err++;
      end
      if (exp_r_q.size() > 0)
      begin
        exp_r   = exp_r_q.pop_front();
        exp_off = exp_off_q.pop_front();
        assert ({rresp, rdata} == exp_r)
        else
        begin
          $display("ERROR: rresp/rdata at 0x%h got 0x%h/0x%h expected 0x%h/0x%h",
                   exp_off, rresp, rdata, exp_r[33:32], exp_r[31:0]);
          val_err++;
        end
      end
    end
  end

  always @(posedge clk_main_a0)
  begin
    cycles++;
    if (cycles == max_cycles)
    begin
      $display("timeout, run still going after %0d cycles", max_cycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // test sequence
  // ------------------------------------------------------------
  initial
  begin
    rst_main_n = 1'b0;
    awvalid    = 1'b0;
    wvalid     = 1'b0;
    arvalid    = 1'b0;
    awaddr     = '0;
    araddr     = '0;
    wdata      = '0;
    wstrb      = '0;
    for (int i = 0; i < 16; i++)
      shadow[i] = '0;                              // every register resets to zero
    repeat (10) @(posedge clk_main_a0);
    #1;
    assert ({awready, wready, arready, bvalid, rvalid} == 5'h0)
    else
    begin
      $display("ERROR: awready/wready/arready/bvalid/rvalid got 0x%h expected 0x00",
               {awready, wready, arready, bvalid, rvalid});
      val_err++;
    end
    rst_main_n = 1'b1;
    @(posedge clk_main_a0);
    #1;
    assert (awready && wready && arready)          // readies up one cycle after reset
    else
    begin
      $display("ERROR: awready/wready/arready got 0x%h expected 0x7",
               {awready, wready, arready});
      val_err++;
    end
    // id, status and version words
    axi_read(reg_id0, 1'b1);
    axi_read(reg_id1, 1'b1);
    axi_read(reg_status, 1'b1);
    axi_read(reg_version, 1'b1);
    axi_read(reg_ctrl, 1'b1);
    // strobed writes with read-back
    for (int i = 0; i < 12; i++)
    begin
      rnd = $random(seed);
      d0  = $random(seed);
      case (rnd[1:0])
        2'd0:    d1 = {24'h0, reg_tick_value};
        2'd1:    d1 = {24'h0, reg_load_value};
        default: d1 = {24'h0, reg_watermark};
      endcase
      axi_write(d1[7:0], d0, rnd[7:4], 1'b1);
      axi_read(d1[7:0], 1'b1);
    end
    axi_write(reg_status, 32'hFFFF_FFFF, 4'hF, 1'b1);  // read-only target
    axi_write(8'h40, 32'h1234_5678, 4'hF, 1'b1);       // hole
    axi_read(8'h40, 1'b1);
    axi_read(reg_tick_value, 1'b1);
    axi_read(reg_load_value, 1'b1);
    axi_read(reg_watermark, 1'b1);
    // load and clear with the counter stopped
    d0 = $random(seed);
    axi_write(reg_load_value, d0, 4'hF, 1'b1);
    axi_write(reg_ctrl, 32'h4, 4'h1, 1'b1);
    axi_read(reg_count, 1'b1);
    axi_write(reg_tick_value, 32'hFF, 4'h1, 1'b1);  // slow prescaler, count holds
    axi_write(reg_ctrl, 32'h1, 4'h1, 1'b1);         // tick_count moves off 0
    axi_write(reg_ctrl, 32'h8, 4'h1, 1'b1);
    axi_read(reg_count, 1'b1);
    axi_read(reg_tick_count, 1'b1);
    // watermark flag
    for (int i = 0; i < 8; i++)
    begin
      d0 = $random(seed);
      d1 = (i == 0) ? d0 : $random(seed);          // first pass hits the equal case
      axi_write(reg_load_value, d0, 4'hF, 1'b1);
      axi_write(reg_watermark, d1, 4'hF, 1'b1);
      axi_write(reg_ctrl, 32'h4, 4'h1, 1'b1);
      axi_read(reg_flags, 1'b1);
    end
    // one-shot saturation
    axi_write(reg_tick_value, 32'h0, 4'hF, 1'b1);
    axi_write(reg_load_value, 32'hFFF0, 4'hF, 1'b1);
    axi_write(reg_ctrl, 32'h4, 4'h1, 1'b1);
    axi_write(reg_ctrl, 32'h3, 4'h1, 1'b1);      // enable + oneshot
    repeat (200) @(posedge clk_main_a0);
    #1;
    shadow[8] = 32'hFFFF;                        // held at the top
    axi_read(reg_count, 1'b1);
    axi_write(reg_ctrl, 32'h8, 4'h1, 1'b1);      // clear, disable
    axi_read(reg_count, 1'b1);
    // back to back under heavy back-pressure
    heavy_stall = 1'b1;
    for (int i = 0; i < 24; i++)
    begin
      rnd = $random(seed);
      d0  = $random(seed);
      if (i % 2 == 1)
        axi_write(rnd[0] ? reg_load_value : reg_watermark, d0, rnd[7:4], 1'b0);
      else if (i % 6 == 4)
        axi_read(8'h40, 1'b0);
      else
        axi_read(rnd[0] ? reg_tick_value : reg_status, 1'b0);
    end
    wait (b_cnt == wr_req && r_cnt == rd_req);
    heavy_stall = 1'b0;
    repeat (20) @(posedge clk_main_a0);          // room for a stray extra response
    #1;
    assert (b_cnt == wr_req && r_cnt == rd_req && exp_b_q.size() == 0 && exp_r_q.size() == 0)
    else
    begin
      $display("response count does not match request count");
      proto_err++;
    end
    $display("done: %0d value errors, %0d other errors, writes %0d/%0d, reads %0d/%0d",
             val_err, proto_err, b_cnt, wr_req, r_cnt, rd_req);
    if (val_err == 0 && proto_err == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

// ==== cl_tick_counter_properties.sv ====
`timescale 1ns/1ps

module cl_tick_counter_properties import cl_tick_pkg::*;
(
  input logic              clk_main_a0,
  input logic              rst_main_n,
  input logic              m_bvalid,
  input logic              m_bready,
  input logic [1:0]        m_bresp,
  input logic              m_rvalid,
  input logic              m_rready,
  input logic [data_w-1:0] m_rdata,
  input logic [1:0]        m_rresp
);

  // ------------------------------------------------------------
  // response channels hold while stalled
  // ------------------------------------------------------------
  b_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    (m_bvalid && !m_bready) |=> (m_bvalid && $stable(m_bresp)))
    else $error("b channel changed while stalled");

  r_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n)
    (m_rvalid && !m_rready) |=> (m_rvalid && $stable(m_rdata) && $stable(m_rresp)))
    else $error("r channel changed while stalled");

endmodule

// ==== cl_tick_counter_top.sv ====
`timescale 1ns/1ps

module cl_tick_counter_top import cl_tick_pkg::*;
#(
  parameter logic [data_w-1:0] cl_id0     = 32'hF000_1D0F,
  parameter logic [data_w-1:0] cl_id1     = 32'h1D51_FEDC,
  parameter logic [data_w-1:0] cl_version = 32'hEEEE_EE00
)
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n,
  input  logic              awvalid,
  input  logic [addr_w-1:0] awaddr,
  output logic              awready,
  input  logic              wvalid,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  output logic              wready,
  output logic              bvalid,
  output logic [1:0]        bresp,
  input  logic              bready,
  input  logic              arvalid,
  input  logic [addr_w-1:0] araddr,
  output logic              arready,
  output logic              rvalid,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  input  logic              rready
);

  // ------------------------------------------------------------
  // slice to register file
  // ------------------------------------------------------------
  logic              m_awvalid, m_awready, m_wvalid, m_wready;
  logic              m_bvalid, m_bready, m_arvalid, m_arready;
  logic              m_rvalid, m_rready;
  logic [addr_w-1:0] m_awaddr, m_araddr;
  logic [data_w-1:0] m_wdata, m_rdata;
  logic [strb_w-1:0] m_wstrb;
  logic [1:0]        m_bresp, m_rresp;

  // register file to counter
  logic              enable, oneshot, load, clear, tick, ge_watermark;
  logic [tick_w-1:0] tick_value, tick_count;
  logic [cnt_w-1:0]  load_value, watermark, count;

  ocl_reg_slice u_slice (.*);  // timing stage on the host port

  ocl_reg_file #(
    .cl_id0     (cl_id0),
    .cl_id1     (cl_id1),
    .cl_version (cl_version)
  ) u_regs (.*);

  tick_counter u_counter (.*);

endmodule

// ==== tick_counter.sv ====
`timescale 1ns/1ps

module tick_counter import cl_tick_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n,
  input  logic              enable,        // level, counting allowed
  input  logic              oneshot,       // level, saturate instead of wrap
  input  logic              load,          // pulse, count <= load_value
  input  logic              clear,         // pulse, count and prescaler to 0
  input  logic [tick_w-1:0] tick_value,
  input  logic [cnt_w-1:0]  load_value,
  input  logic [cnt_w-1:0]  watermark,
  output logic [cnt_w-1:0]  count,
  output logic [tick_w-1:0] tick_count,
  output logic              tick,
  output logic              ge_watermark
);

  logic [tick_w-1:0] tick_count_q, tick_count_nxt;
  logic [cnt_w-1:0]  count_q, count_nxt;
  logic              tick_q, ge_q;
  logic              tick_hit;    // prescaler reached its terminal value
  logic              cnt_at_max;  // count is all ones

  assign tick_hit   = (tick_count_q >= tick_value);
  assign cnt_at_max = &count_q;

  // ------------------------------------------------------------
  // next state
  // ------------------------------------------------------------
  always_comb
  begin
    tick_count_nxt = tick_count_q;
    if (clear)
      tick_count_nxt = '0;
    else if (enable)
      tick_count_nxt = tick_hit ? '0 : tick_count_q + 1'b1;  // 0..tick_value then wrap
  end

  always_comb
  begin
    count_nxt = count_q;
    if (clear)
      count_nxt = '0;                                 // clear wins over load
    else if (load)
      count_nxt = load_value;
    else if (enable && tick_hit && !(oneshot && cnt_at_max))
      count_nxt = count_q + 1'b1;                     // wraps when oneshot is low
  end

  // ------------------------------------------------------------
  // state and registered flags
  // ------------------------------------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      tick_count_q <= '0;
      count_q      <= '0;
      tick_q       <= 1'b0;
      ge_q         <= 1'b0;
    end
    else
    begin
      tick_count_q <= tick_count_nxt;
      count_q      <= count_nxt;
      tick_q       <= (tick_count_nxt >= tick_value);  // lines up with tick_count
      ge_q         <= (count_nxt >= watermark);        // lines up with count
    end
  end

  assign count        = count_q;
  assign tick_count   = tick_count_q;
  assign tick         = tick_q;
  assign ge_watermark = ge_q;

endmodule

// ==== ocl_reg_file.sv ====
`timescale 1ns/1ps

module ocl_reg_file import cl_tick_pkg::*;
#(
  parameter logic [data_w-1:0] cl_id0     = '0,
  parameter logic [data_w-1:0] cl_id1     = '0,
  parameter logic [data_w-1:0] cl_version = '0
)
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n,
  // axi-lite slave
  input  logic              m_awvalid,
  input  logic [addr_w-1:0] m_awaddr,
  output logic              m_awready,
  input  logic              m_wvalid,
  input  logic [data_w-1:0] m_wdata,
  input  logic [strb_w-1:0] m_wstrb,
  output logic              m_wready,
  output logic              m_bvalid,
  output logic [1:0]        m_bresp,
  input  logic              m_bready,
  input  logic              m_arvalid,
  input  logic [addr_w-1:0] m_araddr,
  output logic              m_arready,
  output logic              m_rvalid,
  output logic [data_w-1:0] m_rdata,
  output logic [1:0]        m_rresp,
  input  logic              m_rready,
  // counter control and status
  output logic              enable,
  output logic              oneshot,
  output logic              load,
  output logic              clear,
  output logic [tick_w-1:0] tick_value,
  output logic [cnt_w-1:0]  load_value,
  output logic [cnt_w-1:0]  watermark,
  input  logic [cnt_w-1:0]  count,
  input  logic [tick_w-1:0] tick_count,
  input  logic              tick,
  input  logic              ge_watermark
);

  typedef enum logic {st_idle, st_resp} resp_st_e;

  resp_st_e          wr_st_q, rd_st_q;       // one response slot per path
  reg_off_e          wr_off, rd_off;
  logic              wr_take, rd_take;
  logic              wr_ok, wr_map_ok, rd_ok;
  logic [data_w-1:0] rd_mux;
  logic [data_w-1:0] tick_merge, load_merge, wm_merge;
  resp_e             bresp_q, rresp_q;
  logic [data_w-1:0] rdata_q;
  logic              enable_q, oneshot_q, load_q, clear_q;
  logic [tick_w-1:0] tick_value_q;
  logic [cnt_w-1:0]  load_value_q, watermark_q;

  // merge the strobed byte lanes of new_val into old_val
  function automatic logic [data_w-1:0] apply_strb(input logic [data_w-1:0] old_val,
                                                   input logic [data_w-1:0] new_val,
                                                   input logic [strb_w-1:0] strb);
    logic [data_w-1:0] res;
    res = old_val;
    for (int b = 0; b < strb_w; b++)
    begin
      if (strb[b])
        res[8*b +: 8] = new_val[8*b +: 8];
    end
    return res;
  endfunction

  // ------------------------------------------------------------
  // write path
  // ------------------------------------------------------------
  assign wr_off    = reg_off_e'(m_awaddr[off_w-1:0]);
  assign m_awready = m_wvalid & (wr_st_q == st_idle);   // aw and w taken together
  assign m_wready  = m_awvalid & (wr_st_q == st_idle);
  assign wr_take   = m_awvalid & m_wvalid & (wr_st_q == st_idle);

  always_comb
  begin
    case (wr_off)
      reg_ctrl, reg_tick_value, reg_load_value, reg_watermark: wr_map_ok = 1'b1;
      default: wr_map_ok = 1'b0;                        // read-only or hole
    endcase
    wr_ok = wr_map_ok & (m_awaddr[addr_w-1:off_w] == '0);
  end

  assign tick_merge = apply_strb(data_w'(tick_value_q), m_wdata, m_wstrb);
  assign load_merge = apply_strb(data_w'(load_value_q), m_wdata, m_wstrb);
  assign wm_merge   = apply_strb(data_w'(watermark_q), m_wdata, m_wstrb);

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      enable_q     <= rst_ctrl[ctrl_enable_bit];
      oneshot_q    <= rst_ctrl[ctrl_oneshot_bit];
      load_q       <= 1'b0;
      clear_q      <= 1'b0;
      tick_value_q <= rst_tick_value;
      load_value_q <= rst_load_value;
      watermark_q  <= rst_watermark;
    end
    else
    begin
      load_q  <= 1'b0;                                  // pulses last one cycle
      clear_q <= 1'b0;
      if (wr_take && wr_ok)
      begin
        case (wr_off)
          reg_ctrl:
          begin
            if (m_wstrb[0])                             // every ctrl bit sits in lane 0
            begin
              enable_q  <= m_wdata[ctrl_enable_bit];
              oneshot_q <= m_wdata[ctrl_oneshot_bit];
              load_q    <= m_wdata[ctrl_load_bit];
              clear_q   <= m_wdata[ctrl_clear_bit];
            end
          end
          reg_tick_value: tick_value_q <= tick_merge[tick_w-1:0];
          reg_load_value: load_value_q <= load_merge[cnt_w-1:0];
          reg_watermark:  watermark_q  <= wm_merge[cnt_w-1:0];
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      wr_st_q <= st_idle;
    else if (wr_take)
      wr_st_q <= st_resp;
    else if (m_bready)
      wr_st_q <= st_idle;                               // response taken
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (wr_take)
      bresp_q <= wr_ok ? resp_okay : resp_slverr;
  end

  // ------------------------------------------------------------
  // read path
  // ------------------------------------------------------------
  assign rd_off    = reg_off_e'(m_araddr[off_w-1:0]);
  assign m_arready = (rd_st_q == st_idle);
  assign rd_take   = m_arvalid & m_arready;

  always_comb
  begin
    rd_mux = '0;
    rd_ok  = (m_araddr[addr_w-1:off_w] == '0);
    case (rd_off)
      reg_id0:        rd_mux = cl_id0;
      reg_id1:        rd_mux = cl_id1;
      reg_status:     rd_mux = status_word;
      reg_version:    rd_mux = cl_version;
      reg_ctrl:
      begin
        rd_mux[ctrl_enable_bit]  = enable_q;            // load/clear read back 0
        rd_mux[ctrl_oneshot_bit] = oneshot_q;
      end
      reg_tick_value: rd_mux = data_w'(tick_value_q);
      reg_load_value: rd_mux = data_w'(load_value_q);
      reg_watermark:  rd_mux = data_w'(watermark_q);
      reg_count:      rd_mux = data_w'(count);
      reg_tick_count: rd_mux = data_w'(tick_count);
      reg_flags:
      begin
        rd_mux[flags_ge_bit]   = ge_watermark;
        rd_mux[flags_tick_bit] = tick;
      end
      default:        rd_ok  = 1'b0;
    endcase
    if (!rd_ok)
      rd_mux = '0;                                      // unmapped reads return zero
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
      rd_st_q <= st_idle;
    else if (rd_take)
      rd_st_q <= st_resp;
    else if (m_rready)
      rd_st_q <= st_idle;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (rd_take)
    begin
      rdata_q <= rd_mux;                                // sampled at the ar transfer
      rresp_q <= rd_ok ? resp_okay : resp_slverr;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign m_bvalid   = (wr_st_q == st_resp);
  assign m_bresp    = bresp_q;
  assign m_rvalid   = (rd_st_q == st_resp);
  assign m_rdata    = rdata_q;
  assign m_rresp    = rresp_q;
  assign enable     = enable_q;
  assign oneshot    = oneshot_q;
  assign load       = load_q;
  assign clear      = clear_q;
  assign tick_value = tick_value_q;
  assign load_value = load_value_q;
  assign watermark  = watermark_q;

endmodule

// ==== ocl_reg_slice.sv ====
`timescale 1ns/1ps

module ocl_reg_slice import cl_tick_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n,
  // host side
  input  logic              awvalid,
  input  logic [addr_w-1:0] awaddr,
  output logic              awready,
  input  logic              wvalid,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  output logic              wready,
  output logic              bvalid,
  output logic [1:0]        bresp,
  input  logic              bready,
  input  logic              arvalid,
  input  logic [addr_w-1:0] araddr,
  output logic              arready,
  output logic              rvalid,
  output logic [data_w-1:0] rdata,
  output logic [1:0]        rresp,
  input  logic              rready,
  // register file side
  output logic              m_awvalid,
  output logic [addr_w-1:0] m_awaddr,
  input  logic              m_awready,
  output logic              m_wvalid,
  output logic [data_w-1:0] m_wdata,
  output logic [strb_w-1:0] m_wstrb,
  input  logic              m_wready,
  input  logic              m_bvalid,
  input  logic [1:0]        m_bresp,
  output logic              m_bready,
  output logic              m_arvalid,
  output logic [addr_w-1:0] m_araddr,
  input  logic              m_arready,
  input  logic              m_rvalid,
  input  logic [data_w-1:0] m_rdata,
  input  logic [1:0]        m_rresp,
  output logic              m_rready
);

  // channel slots in the handshake vectors
  localparam int n_ch  = 5;
  localparam int ch_aw = 0;
  localparam int ch_w  = 1;
  localparam int ch_b  = 2;
  localparam int ch_ar = 3;
  localparam int ch_r  = 4;

  logic [n_ch-1:0]   in_valid;    // producer side valid per channel
  logic [n_ch-1:0]   in_ready;    // producer side ready per channel
  logic [n_ch-1:0]   out_ready;   // consumer side ready per channel
  logic [n_ch-1:0]   take;        // entry loads this cycle
  logic [n_ch-1:0]   full_q;      // entry holds an item
  logic              ready_en_q;  // readies stay low until out of reset
  logic [addr_w-1:0] awaddr_q;
  logic [data_w-1:0] wdata_q;
  logic [strb_w-1:0] wstrb_q;
  logic [1:0]        bresp_q;
  logic [addr_w-1:0] araddr_q;
  logic [data_w-1:0] rdata_q;
  logic [1:0]        rresp_q;

  // ------------------------------------------------------------
  // handshake, shared by all five channels
  // ------------------------------------------------------------
  assign in_valid  = {m_rvalid, arvalid, m_bvalid, wvalid, awvalid};
  assign out_ready = {rready, m_arready, bready, m_wready, m_awready};

  assign in_ready = {n_ch{ready_en_q}} & (~full_q | out_ready);  // empty or draining
  assign take     = in_valid & in_ready;

  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n)
    begin
      ready_en_q <= 1'b0;
      full_q     <= '0;
    end
    else
    begin
      ready_en_q <= 1'b1;
      full_q     <= take | (full_q & ~in_ready);  // refill, drain or hold
    end
  end

  // payload flops, loaded only on a transfer in
  always_ff @(posedge clk_main_a0)
  begin
    if (take[ch_aw])
      awaddr_q <= awaddr;
    if (take[ch_w])
    begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (take[ch_b])
      bresp_q <= m_bresp;
    if (take[ch_ar])
      araddr_q <= araddr;
    if (take[ch_r])
    begin
      rdata_q <= m_rdata;
      rresp_q <= m_rresp;
    end
  end

  // ------------------------------------------------------------
  // outputs
  // ------------------------------------------------------------
  assign awready   = in_ready[ch_aw];
  assign wready    = in_ready[ch_w];
  assign m_bready  = in_ready[ch_b];
  assign arready   = in_ready[ch_ar];
  assign m_rready  = in_ready[ch_r];

  assign m_awvalid = full_q[ch_aw];
  assign m_awaddr  = awaddr_q;
  assign m_wvalid  = full_q[ch_w];
  assign m_wdata   = wdata_q;
  assign m_wstrb   = wstrb_q;
  assign bvalid    = full_q[ch_b];
  assign bresp     = bresp_q;
  assign m_arvalid = full_q[ch_ar];
  assign m_araddr  = araddr_q;
  assign rvalid    = full_q[ch_r];
  assign rdata     = rdata_q;
  assign rresp     = rresp_q;

endmodule

// ==== cl_tick_pkg.sv ====
package cl_tick_pkg;

  // ------------------------------------------------------------
  // bus and datapath widths
  // ------------------------------------------------------------
  localparam int addr_w = 32;          // ocl byte address
  localparam int data_w = 32;          // register word
  localparam int strb_w = data_w / 8;  // one strobe per byte lane
  localparam int off_w  = 8;           // low address bits that pick a register
  localparam int tick_w = 8;           // prescaler width
  localparam int cnt_w  = 16;          // main counter width

  // axi-lite response codes, only the two we ever return
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_slverr = 2'b10
  } resp_e;

  // ------------------------------------------------------------
  // register map, word aligned byte offsets
  // ------------------------------------------------------------
  typedef enum logic [off_w-1:0] {
    reg_id0        = 8'h00,  // ro, cl_id0 parameter
    reg_id1        = 8'h04,  // ro, cl_id1 parameter
    reg_status     = 8'h08,  // ro, constant status word
    reg_version    = 8'h0C,  // ro, cl_version parameter
    reg_ctrl       = 8'h10,  // rw, enable/oneshot plus load/clear pulses
    reg_tick_value = 8'h14,  // rw, prescaler terminal value
    reg_load_value = 8'h18,  // rw, value taken by a load pulse
    reg_watermark  = 8'h1C,  // rw, compare level for the flag
    reg_count      = 8'h20,  // ro, main counter
    reg_tick_count = 8'h24,  // ro, prescaler
    reg_flags      = 8'h28   // ro, watermark and tick flags
  } reg_off_e;

  localparam logic [data_w-1:0] status_word = 32'h0000_0FF0;

  // ctrl register bits, all in byte lane 0
  localparam int ctrl_enable_bit  = 0;  // stored
  localparam int ctrl_oneshot_bit = 1;  // stored
  localparam int ctrl_load_bit    = 2;  // write-1 pulse, reads 0
  localparam int ctrl_clear_bit   = 3;  // write-1 pulse, reads 0

  // flags register bits
  localparam int flags_ge_bit   = 0;  // count >= watermark
  localparam int flags_tick_bit = 1;  // prescaler at terminal value

  // reset values of the writable registers
  localparam logic [data_w-1:0] rst_ctrl       = '0;
  localparam logic [tick_w-1:0] rst_tick_value = '0;
  localparam logic [cnt_w-1:0]  rst_load_value = '0;
  localparam logic [cnt_w-1:0]  rst_watermark  = '0;

endpackage
